// ==== project.f ====
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_imm_gen.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_commit_unit.sv
hdl/rv_exec_core.sv
sim/tb_rv_exec_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module tb_rv_exec_core -f project.f \
    && ./obj_dir/Vtb_rv_exec_core | tee /dev/stderr | grep -qx "ALL CHECKS PASSED" \
    || { echo "simulation did not pass"; exit 1; }

// ==== sim/tb_rv_exec_core.sv ====
`timescale 1ns/100ps

module tb_rv_exec_core;

    localparam rv_pkg::rv_addr_t RESET_PC       = 32'h0000_0200;
    localparam int               NUM_INSTR      = 2000;
    localparam int               TIMEOUT_CYCLES = NUM_INSTR * 3 + 100;

    logic               clk_i;
    logic               rst_n_i;
    logic               instr_valid_i;
    rv_pkg::rv_word_t   instr_i;
    rv_pkg::rv_retire_t retire_o;

    rv_pkg::rv_word_t   model_regs [0:31];
    rv_pkg::rv_addr_t   model_pc;
    rv_pkg::rv_retire_t exp_q [$];     // pending retires in program order
    int                 cyc_q [$];     // cycle each one was driven
    rv_pkg::rv_retire_t drive_rec;
    rv_pkg::rv_word_t   drive_instr;
    int                 issued       = 0;
    int                 cycle_count  = 0;
    int                 check_count  = 0;
    int                 value_errors = 0;
    int                 pulse_errors = 0;
    int                 r;

    rv_exec_core #(.RESET_PC(RESET_PC)) u_rv_exec_core (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .instr_valid_i(instr_valid_i),
        .instr_i      (instr_i),
        .retire_o     (retire_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle_count <= cycle_count + 1;

    // ========================================================================
    // compare tasks
    // ========================================================================
    task automatic check_word(input string name, input rv_pkg::rv_word_t got,
                              input rv_pkg::rv_word_t exp);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %0t: %s is %h, expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_addr(input string name, input rv_pkg::rv_addr_t got,
                              input rv_pkg::rv_addr_t exp);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %0t: %s is %h, expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_idx(input string name, input rv_pkg::rv_reg_idx_t got,
                             input rv_pkg::rv_reg_idx_t exp);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %0t: %s is x%0d, expected x%0d", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %0t: %s is %b, expected %b", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic report_counts();
        $display("checks %0d, value errors %0d, pulse errors %0d, issued %0d",
                 check_count, value_errors, pulse_errors, issued);
    endtask

    // ========================================================================
    // stimulus and reference model
    // ========================================================================
    function automatic rv_pkg::rv_word_t random_instr();
        int unsigned pick;
        int unsigned kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic        alt;
        pick  = $urandom_range(0, 99);
        kind  = $urandom_range(0, 3);
        rd    = 5'($urandom_range(0, 7));  // few registers so values get reused
        rs1   = 5'($urandom_range(0, 7));
        rs2   = 5'($urandom_range(0, 7));
        f3    = 3'($urandom_range(0, 7));
        imm12 = 12'($urandom());
        imm20 = 20'($urandom());
        alt   = 1'($urandom_range(0, 1));
        if (pick < 20) begin
            return {1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'b0, rs2, rs1, f3, rd,
                    7'b0110011};
        end else if (pick < 40) begin
            if (f3 == 3'b001) imm12 = {7'b0, imm12[4:0]};
            if (f3 == 3'b101) imm12 = {1'b0, alt, 5'b0, imm12[4:0]};  // srli or srai
            return {imm12, rs1, f3, rd, 7'b0010011};
        end else if (pick < 47) begin
            return {imm20, rd, 7'b0110111};
        end else if (pick < 54) begin
            return {imm20, rd, 7'b0010111};
        end else if (pick < 70) begin
            f3 = 3'($urandom_range(0, 5));
            if (f3 >= 3'd2) f3 = f3 + 3'd2;  // 0, 1, 4 .. 7
            return {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b1100011};
        end else if (pick < 78) begin
            return {imm20, rd, 7'b1101111};
        end else if (pick < 90) begin
            return {imm12, rs1, 3'b000, rd, 7'b1100111};
        end
        case (kind)
            1:       return {imm12, rs1, f3, rd, 7'b1110011};  // system
            2:       return {imm12, rs1, f3, rd, alt ? 7'b0000011 : 7'b0100011};
            3:       return {7'b0, rs2, rs1, 2'b01, alt, 5'b0, 7'b1100011};
            default: return {7'b0000001, rs2, rs1, f3, rd, 7'b0110011};  // mul/div
        endcase
    endfunction

    function automatic rv_pkg::rv_word_t alu_ref(input logic [2:0] f3, input logic alt,
                                                 input rv_pkg::rv_word_t a,
                                                 input rv_pkg::rv_word_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_step(input rv_pkg::rv_word_t in, output rv_pkg::rv_retire_t rec);
        rv_pkg::rv_word_t a;
        rv_pkg::rv_word_t b;
        rv_pkg::rv_word_t imm_i;
        rv_pkg::rv_word_t imm_b;
        rv_pkg::rv_word_t imm_u;
        rv_pkg::rv_word_t imm_j;
        logic             taken;
        a     = model_regs[in[19:15]];
        b     = model_regs[in[24:20]];
        imm_i = {{20{in[31]}}, in[31:20]};
        imm_b = {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
        imm_u = {in[31:12], 12'b0};
        imm_j = {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
        taken = 1'b0;
        rec         = '0;
        rec.valid   = 1'b1;
        rec.pc      = model_pc;
        rec.next_pc = model_pc + 32'd4;
        rec.rd      = in[11:7];
        case (in[6:0])
            7'b0110011: begin
                rec.illegal = in[25];
                rec.wb_en   = ~in[25];
                rec.wb_data = alu_ref(in[14:12], in[30], a, b);
            end
            7'b0010011: begin
                rec.wb_en   = 1'b1;
                rec.wb_data = alu_ref(in[14:12], (in[14:12] == 3'b101) && in[30], a, imm_i);
            end
            7'b0110111: {rec.wb_en, rec.wb_data} = {1'b1, imm_u};
            7'b0010111: {rec.wb_en, rec.wb_data} = {1'b1, model_pc + imm_u};
            7'b1100011: begin
                case (in[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    3'b111:  taken = (a >= b);
                    default: rec.illegal = 1'b1;
                endcase
                if (taken) rec.next_pc = model_pc + imm_b;
            end
            7'b1101111: begin
                {rec.wb_en, rec.wb_data} = {1'b1, model_pc + 32'd4};
                rec.next_pc = model_pc + imm_j;
            end
            7'b1100111: begin
                {rec.wb_en, rec.wb_data} = {1'b1, model_pc + 32'd4};
                rec.next_pc = (a + imm_i) & ~32'd1;
            end
            default: rec.illegal = 1'b1;  // loads, stores, system, unknown
        endcase
        if (rec.wb_en && rec.rd != '0) model_regs[rec.rd] = rec.wb_data;
        model_pc = rec.next_pc;
    endtask

    // ========================================================================
    // retire monitor
    // ========================================================================
    always @(negedge clk_i) begin : retire_check
        rv_pkg::rv_retire_t exp_rec;
        int                 drive_cyc;
        if (rst_n_i) begin
            if (retire_o.valid) begin
                if (exp_q.size() == 0) begin
                    $display("%0t: retire pulse seen with no pending instruction", $time);
                    pulse_errors++;
                end else begin
                    exp_rec   = exp_q.pop_front();
                    drive_cyc = cyc_q.pop_front();
                    if (drive_cyc + 2 != cycle_count) begin
                        $display("%0t: retire pulse came in the wrong cycle", $time);
                        pulse_errors++;
                    end
                    check_addr("pc", retire_o.pc, exp_rec.pc);
                    check_addr("next_pc", retire_o.next_pc, exp_rec.next_pc);
                    check_idx("rd", retire_o.rd, exp_rec.rd);
                    check_flag("wb_en", retire_o.wb_en, exp_rec.wb_en);
                    check_flag("illegal", retire_o.illegal, exp_rec.illegal);
                    if (exp_rec.wb_en) check_word("wb_data", retire_o.wb_data, exp_rec.wb_data);
                end
            end else if (cyc_q.size() != 0 && cyc_q[0] + 2 <= cycle_count) begin
                $display("%0t: no retire pulse for the instruction at pc %h",
                         $time, exp_q[0].pc);
                exp_rec   = exp_q.pop_front();
                drive_cyc = cyc_q.pop_front();
                pulse_errors++;
            end
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) @(posedge clk_i);
        $display("timeout after %0d cycles, the run did not finish", cycle_count);
        report_counts();
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(92770));
        instr_valid_i = 1'b0;
        instr_i       = '0;
        rst_n_i       = 1'b0;
        for (r = 0; r < 32; r++) model_regs[r] = '0;
        model_pc = RESET_PC;
        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;
        repeat (3) @(posedge clk_i);  // idle cycles with no pulse allowed
        while (issued < NUM_INSTR) begin
            @(posedge clk_i);
            if ($urandom_range(0, 99) < 30) begin
                instr_valid_i <= 1'b0;
            end else begin
                drive_instr = random_instr();
                model_step(drive_instr, drive_rec);
                exp_q.push_back(drive_rec);
                cyc_q.push_back(cycle_count);
                instr_valid_i <= 1'b1;
                instr_i       <= drive_instr;
                issued++;
            end
        end
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk_i);
        repeat (4) @(posedge clk_i);  // catch stray pulses
        report_counts();
        if (value_errors == 0 && pulse_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/rv_exec_core.sv ====
`timescale 1ns/100ps

module rv_exec_core #(
    parameter rv_pkg::rv_addr_t RESET_PC = 32'h0000_0000
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               instr_valid_i,
    input  rv_pkg::rv_word_t   instr_i,
    output rv_pkg::rv_retire_t retire_o
);

    rv_pkg::rv_ctrl_t    ctrl;
    rv_pkg::rv_word_t    imm;
    rv_pkg::rv_reg_idx_t rs1_idx;
    rv_pkg::rv_reg_idx_t rs2_idx;
    rv_pkg::rv_reg_idx_t rd_idx;
    rv_pkg::rv_word_t    rs1_data;
    rv_pkg::rv_word_t    rs2_data;
    rv_pkg::rv_word_t    op_a;
    rv_pkg::rv_word_t    op_b;
    rv_pkg::rv_word_t    alu_result;
    rv_pkg::rv_addr_t    pc;
    logic                wr_en;
    rv_pkg::rv_reg_idx_t wr_idx;
    rv_pkg::rv_word_t    wr_data;

    // ========================================================================
    // decode
    // ========================================================================
    assign rs1_idx = instr_i[19:15];
    assign rs2_idx = instr_i[24:20];
    assign rd_idx  = instr_i[11:7];

    rv_decoder u_rv_decoder (.instr_i(instr_i), .ctrl_o(ctrl));

    rv_imm_gen u_rv_imm_gen (.instr_i(instr_i), .imm_kind_i(ctrl.imm_kind), .imm_o(imm));

    rv_regfile u_rv_regfile (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .rs1_idx_i (rs1_idx),
        .rs2_idx_i (rs2_idx),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data),
        .wr_en_i   (wr_en),
        .wr_idx_i  (wr_idx),
        .wr_data_i (wr_data)
    );

    // ========================================================================
    // execute and commit
    // ========================================================================
    assign op_a = ctrl.op_a_pc  ? pc  : rs1_data;  // auipc uses pc
    assign op_b = ctrl.op_b_imm ? imm : rs2_data;

    rv_alu u_rv_alu (.op_i(ctrl.alu_op), .a_i(op_a), .b_i(op_b), .result_o(alu_result));

    rv_commit_unit #(.RESET_PC(RESET_PC)) u_rv_commit_unit (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .instr_valid_i(instr_valid_i),
        .ctrl_i       (ctrl),
        .rd_i         (rd_idx),
        .imm_i        (imm),
        .alu_result_i (alu_result),
        .pc_o         (pc),
        .wr_en_o      (wr_en),
        .wr_idx_o     (wr_idx),
        .wr_data_o    (wr_data),
        .retire_o     (retire_o)
    );

endmodule

// ==== hdl/rv_commit_unit.sv ====
`timescale 1ns/100ps

module rv_commit_unit #(
    parameter rv_pkg::rv_addr_t RESET_PC = 32'h0000_0000
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                instr_valid_i,
    input  rv_pkg::rv_ctrl_t    ctrl_i,
    input  rv_pkg::rv_reg_idx_t rd_i,
    input  rv_pkg::rv_word_t    imm_i,
    input  rv_pkg::rv_word_t    alu_result_i,
    output rv_pkg::rv_addr_t    pc_o,
    output logic                wr_en_o,
    output rv_pkg::rv_reg_idx_t wr_idx_o,
    output rv_pkg::rv_word_t    wr_data_o,
    output rv_pkg::rv_retire_t  retire_o
);

    rv_pkg::rv_addr_t   pc_q;
    rv_pkg::rv_addr_t   pc_plus4;
    rv_pkg::rv_addr_t   next_pc;
    rv_pkg::rv_word_t   wb_data;
    logic               wb_en;
    logic               taken;
    rv_pkg::rv_retire_t retire_q;

    assign pc_plus4 = pc_q + 32'd4;
    assign wb_en    = ctrl_i.wb_en & ~ctrl_i.illegal;

    always_comb begin
        case (ctrl_i.branch)
            rv_pkg::BR_EQ:                taken = (alu_result_i == '0);  // rs1 - rs2
            rv_pkg::BR_NE:                taken = (alu_result_i != '0);
            rv_pkg::BR_LT, rv_pkg::BR_LTU: taken = alu_result_i[0];      // slt result
            rv_pkg::BR_GE, rv_pkg::BR_GEU: taken = ~alu_result_i[0];
            default:                      taken = 1'b0;
        endcase
    end

    always_comb begin
        if (ctrl_i.jalr) begin
            next_pc = {alu_result_i[31:1], 1'b0};
        end else if (ctrl_i.jal || taken) begin
            next_pc = pc_q + imm_i;  // j or b immediate
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_comb begin
        case (ctrl_i.wb_src)
            rv_pkg::WB_IMM: wb_data = imm_i;
            rv_pkg::WB_PC4: wb_data = pc_plus4;
            default:        wb_data = alu_result_i;
        endcase
    end

    assign wr_en_o   = instr_valid_i & wb_en;
    assign wr_idx_o  = rd_i;
    assign wr_data_o = wb_data;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q     <= RESET_PC;
            retire_q <= '0;
        end else begin
            retire_q.valid <= instr_valid_i;  // one-cycle pulse
            if (instr_valid_i) begin
                pc_q             <= next_pc;
                retire_q.pc      <= pc_q;
                retire_q.next_pc <= next_pc;
                retire_q.rd      <= rd_i;
                retire_q.wb_en   <= wb_en;
                retire_q.wb_data <= wb_data;
                retire_q.illegal <= ctrl_i.illegal;
            end
        end
    end

    assign pc_o     = pc_q;
    assign retire_o = retire_q;

endmodule

// ==== hdl/rv_alu.sv ====
`timescale 1ns/100ps

module rv_alu (
    input  rv_pkg::rv_alu_op_e op_i,
    input  rv_pkg::rv_word_t   a_i,
    input  rv_pkg::rv_word_t   b_i,
    output rv_pkg::rv_word_t   result_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0];  // rv32 shifts ignore upper bits
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    // ========================================================================
    // operation select
    // ========================================================================
    always_comb begin
        case (op_i)
            rv_pkg::ALU_ADD:  result_o = a_i + b_i;
            rv_pkg::ALU_SUB:  result_o = a_i - b_i;       // zero test for beq/bne
            rv_pkg::ALU_SLL:  result_o = a_i << shamt;
            rv_pkg::ALU_SLT:  result_o = {31'b0, lt_signed};
            rv_pkg::ALU_SLTU: result_o = {31'b0, lt_unsigned};
            rv_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            rv_pkg::ALU_SRL:  result_o = a_i >> shamt;
            rv_pkg::ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
            rv_pkg::ALU_OR:   result_o = a_i | b_i;
            rv_pkg::ALU_AND:  result_o = a_i & b_i;
            default:          result_o = '0;
        endcase
    end

endmodule

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/100ps

module rv_regfile (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  rv_pkg::rv_reg_idx_t rs1_idx_i,
    input  rv_pkg::rv_reg_idx_t rs2_idx_i,
    output rv_pkg::rv_word_t    rs1_data_o,
    output rv_pkg::rv_word_t    rs2_data_o,
    input  logic                wr_en_i,
    input  rv_pkg::rv_reg_idx_t wr_idx_i,
    input  rv_pkg::rv_word_t    wr_data_i
);

    rv_pkg::rv_word_t regs_q [1:31];  // x0 has no storage

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && (wr_idx_i != '0)) begin
            regs_q[wr_idx_i] <= wr_data_i;
        end
    end

    // read ports see the old value until the edge
    assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs_q[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs_q[rs2_idx_i];

endmodule

// ==== hdl/rv_imm_gen.sv ====
`timescale 1ns/100ps

module rv_imm_gen (
    input  rv_pkg::rv_word_t     instr_i,
    input  rv_pkg::rv_imm_kind_e imm_kind_i,
    output rv_pkg::rv_word_t     imm_o
);

    rv_pkg::rv_word_t imm_i_fmt;
    rv_pkg::rv_word_t imm_s_fmt;
    rv_pkg::rv_word_t imm_b_fmt;
    rv_pkg::rv_word_t imm_u_fmt;
    rv_pkg::rv_word_t imm_j_fmt;

    assign imm_i_fmt = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_fmt = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_fmt = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};  // 2-byte aligned
    assign imm_u_fmt = {instr_i[31:12], 12'b0};
    assign imm_j_fmt = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                        instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        case (imm_kind_i)
            rv_pkg::IMM_I: imm_o = imm_i_fmt;
            rv_pkg::IMM_S: imm_o = imm_s_fmt;
            rv_pkg::IMM_B: imm_o = imm_b_fmt;
            rv_pkg::IMM_U: imm_o = imm_u_fmt;
            rv_pkg::IMM_J: imm_o = imm_j_fmt;
            default:       imm_o = '0;  // register-only formats
        endcase
    end

endmodule

// ==== hdl/rv_decoder.sv ====
`timescale 1ns/100ps

module rv_decoder (
    input  rv_pkg::rv_word_t instr_i,
    output rv_pkg::rv_ctrl_t ctrl_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       bit30;  // selects sub and arithmetic shifts
    logic       bit25;  // M extension marker on OP

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign bit30  = instr_i[30];
    assign bit25  = instr_i[25];

    always_comb begin
        ctrl_o.alu_op   = rv_pkg::ALU_ADD;
        ctrl_o.op_a_pc  = 1'b0;   // rs1
        ctrl_o.op_b_imm = 1'b1;   // immediate
        ctrl_o.imm_kind = rv_pkg::IMM_NONE;
        ctrl_o.branch   = rv_pkg::BR_NONE;
        ctrl_o.jal      = 1'b0;
        ctrl_o.jalr     = 1'b0;
        ctrl_o.wb_src   = rv_pkg::WB_ALU;
        ctrl_o.wb_en    = 1'b0;
        ctrl_o.illegal  = 1'b0;
        case (opcode)
            rv_pkg::OPC_OP_IMM: begin
                ctrl_o.imm_kind = rv_pkg::IMM_I;
                ctrl_o.wb_en    = 1'b1;
                case (funct3)
                    3'b000: ctrl_o.alu_op = rv_pkg::ALU_ADD;   // addi
                    3'b001: ctrl_o.alu_op = rv_pkg::ALU_SLL;   // slli
                    3'b010: ctrl_o.alu_op = rv_pkg::ALU_SLT;   // slti
                    3'b011: ctrl_o.alu_op = rv_pkg::ALU_SLTU;  // sltiu
                    3'b100: ctrl_o.alu_op = rv_pkg::ALU_XOR;   // xori
                    3'b101: ctrl_o.alu_op = bit30 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'b110: ctrl_o.alu_op = rv_pkg::ALU_OR;    // ori
                    3'b111: ctrl_o.alu_op = rv_pkg::ALU_AND;   // andi
                endcase
            end
            rv_pkg::OPC_OP: begin
                ctrl_o.op_b_imm = 1'b0;
                ctrl_o.wb_en    = 1'b1;
                ctrl_o.illegal  = bit25;  // mul/div not supported
                case (funct3)
                    3'b000: ctrl_o.alu_op = bit30 ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b001: ctrl_o.alu_op = rv_pkg::ALU_SLL;
                    3'b010: ctrl_o.alu_op = rv_pkg::ALU_SLT;
                    3'b011: ctrl_o.alu_op = rv_pkg::ALU_SLTU;
                    3'b100: ctrl_o.alu_op = rv_pkg::ALU_XOR;
                    3'b101: ctrl_o.alu_op = bit30 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'b110: ctrl_o.alu_op = rv_pkg::ALU_OR;
                    3'b111: ctrl_o.alu_op = rv_pkg::ALU_AND;
                endcase
            end
            rv_pkg::OPC_AUIPC: begin
                ctrl_o.imm_kind = rv_pkg::IMM_U;
                ctrl_o.op_a_pc  = 1'b1;  // pc + imm
                ctrl_o.wb_en    = 1'b1;
            end
            rv_pkg::OPC_LUI: begin
                ctrl_o.imm_kind = rv_pkg::IMM_U;
                ctrl_o.wb_src   = rv_pkg::WB_IMM;
                ctrl_o.wb_en    = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                ctrl_o.imm_kind = rv_pkg::IMM_B;
                ctrl_o.op_b_imm = 1'b0;  // compare rs1 with rs2
                case (funct3)
                    3'b000: begin
                        ctrl_o.alu_op = rv_pkg::ALU_SUB;
                        ctrl_o.branch = rv_pkg::BR_EQ;
                    end
                    3'b001: begin
                        ctrl_o.alu_op = rv_pkg::ALU_SUB;
                        ctrl_o.branch = rv_pkg::BR_NE;
                    end
                    3'b100: begin
                        ctrl_o.alu_op = rv_pkg::ALU_SLT;
                        ctrl_o.branch = rv_pkg::BR_LT;
                    end
                    3'b101: begin
                        ctrl_o.alu_op = rv_pkg::ALU_SLT;
                        ctrl_o.branch = rv_pkg::BR_GE;
                    end
                    3'b110: begin
                        ctrl_o.alu_op = rv_pkg::ALU_SLTU;
                        ctrl_o.branch = rv_pkg::BR_LTU;
                    end
                    3'b111: begin
                        ctrl_o.alu_op = rv_pkg::ALU_SLTU;
                        ctrl_o.branch = rv_pkg::BR_GEU;
                    end
                    default: ctrl_o.illegal = 1'b1;
                endcase
            end
            rv_pkg::OPC_JALR: begin
                ctrl_o.imm_kind = rv_pkg::IMM_I;  // target is rs1 + imm
                ctrl_o.jalr     = 1'b1;
                ctrl_o.wb_src   = rv_pkg::WB_PC4;
                ctrl_o.wb_en    = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                ctrl_o.imm_kind = rv_pkg::IMM_J;
                ctrl_o.jal      = 1'b1;
                ctrl_o.wb_src   = rv_pkg::WB_PC4;
                ctrl_o.wb_en    = 1'b1;
            end
            rv_pkg::OPC_SYSTEM: ctrl_o.illegal = 1'b1;  // no csr, ecall or mret here
            default:            ctrl_o.illegal = 1'b1;  // loads, stores, unknown
        endcase
    end

endmodule

// ==== hdl/rv_pkg.sv ====
package rv_pkg;

    // ========================================================================
    // word types
    // ========================================================================
    typedef logic [31:0] rv_word_t;     // data word or instruction
    typedef logic [31:0] rv_addr_t;     // program counter value
    typedef logic [4:0]  rv_reg_idx_t;  // x0 .. x31

    // base opcodes handled by the decoder
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // ========================================================================
    // control encodings
    // ========================================================================
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } rv_alu_op_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } rv_imm_kind_e;

    typedef enum logic [1:0] {
        WB_ALU,  // alu result
        WB_IMM,  // u immediate for lui
        WB_PC4   // link address
    } rv_wb_src_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } rv_branch_e;

    typedef struct packed {
        rv_alu_op_e   alu_op;
        logic         op_a_pc;   // operand a is pc
        logic         op_b_imm;  // operand b is the immediate
        rv_imm_kind_e imm_kind;
        rv_branch_e   branch;
        logic         jal;
        logic         jalr;
        rv_wb_src_e   wb_src;
        logic         wb_en;
        logic         illegal;
    } rv_ctrl_t;

    typedef struct packed {
        logic        valid;
        rv_addr_t    pc;
        rv_addr_t    next_pc;
        rv_reg_idx_t rd;
        logic        wb_en;
        rv_word_t    wb_data;
        logic        illegal;
    } rv_retire_t;

endpackage
